// File: common/hangmanPkg.sv
// Shared types and constants for the hangman game core.
// Import with a wildcard inside a module body. Module headers use scoped
// names such as hangmanPkg::wordT.

package hangmanPkg;

    // Number of letters in the secret word.
    localparam int unsigned wordLen = 5;

    // ASCII letter, zero means no key held.
    typedef logic [7:0] letterT;

    // Flat view for shifting, array view for per-letter access.
    // Element wordLen-1 holds the first letter of the word.
    typedef union packed {
        logic [8*wordLen-1:0] flat;
        letterT [wordLen-1:0] letters;
    } wordT;

    // Correct positions and mistakes.
    typedef logic [2:0] countT;

    // Found positions, MSB is the first letter.
    typedef logic [wordLen-1:0] maskT;

    // Shown for positions not yet revealed.
    localparam letterT blankChar = 8'h5F;

endpackage

// File: common/gameStatusIf.sv
// Game status bus from the game logic to the display block.
// The game modport drives the found mask, the mistake count and both lamps.
// The disp modport only reads them.

`timescale 1ns/1ps

interface gameStatusIf;
    import hangmanPkg::*;

    maskT  indexCorrect;
    countT incorrect;
    logic  red;
    logic  green;

    modport game (
        output indexCorrect,
        output incorrect,
        output red,
        output green
    );

    modport disp (
        input indexCorrect,
        input incorrect,
        input red,
        input green
    );

endinterface

// File: src/wordLoader.sv
// Secret word loader.
// While setup is high, each host strobe shifts one letter into the low byte
// of the word, so the first letter ends up in the top byte after five.
// Strobes beyond five letters are ignored. The letter count restarts when
// setup rises for a new game; the old letters stay until overwritten.

`timescale 1ns/1ps

module wordLoader (
    input  logic               clk,
    input  logic               nRst,
    input  logic               setup,
    input  hangmanPkg::letterT hostLetter,
    input  logic               hostStrobe,
    output hangmanPkg::wordT   secretWord,
    output logic               wordFull
);
    import hangmanPkg::*;

    countT letterCount;
    countT baseCount;
    logic  setupQ;
    logic  take;

    // Count starts over on the first setup cycle of a new game.
    assign baseCount = (setup && !setupQ) ? '0 : letterCount;

    assign take = setup && hostStrobe && (baseCount < countT'(wordLen));

    assign wordFull = (letterCount == countT'(wordLen));

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            letterCount <= '0;
            setupQ      <= 1'b1;
        end else begin
            setupQ <= setup;
            if (take) begin
                letterCount <= baseCount + countT'(1);
            end else begin
                letterCount <= baseCount;
            end
        end
    end

    // Earlier letters move toward the first position.
    always_ff @(posedge clk) begin
        if (take) begin
            secretWord.flat <= {secretWord.flat[8*wordLen-9:0], hostLetter};
        end
    end

endmodule

// File: gameLogic/gameLogic.sv
// Hangman game state machine.
// SET waits for the host to confirm the word. In IDLE a new nonzero guess
// starts a five cycle compare, one word position per cycle (L0 to L4).
// STOP scores the guess: found positions add to correct, no hit adds a
// mistake and pulses mistake. Win and loss lamps latch in IDLE and hold
// until gameEnd returns the game to SET.

`timescale 1ns/1ps

module gameLogic #(
    parameter int unsigned maxMistakes = 6
) (
    input  logic               clk,
    input  logic               nRst,
    input  logic               confirm,
    input  hangmanPkg::letterT guess,
    input  logic               gameEnd,
    input  hangmanPkg::wordT   secretWord,
    output logic               setup,
    output logic               gameRdy,
    output logic               busy,
    output logic               mistake,
    output hangmanPkg::countT  correct,
    gameStatusIf.game          status
);
    import hangmanPkg::*;

    typedef enum logic [2:0] {
        SET,
        L0,
        L1,
        L2,
        L3,
        L4,
        STOP,
        IDLE
    } stateT;

    stateT  state;
    stateT  nextState;
    letterT lastLetter;
    countT  hits;
    maskT   found;
    countT  correctQ;
    countT  mistakes;
    logic   redQ;
    logic   greenQ;
    logic   [2:0] pos;
    logic   hit;
    logic   gameOver;
    logic   accept;

    assign gameOver = (correctQ == countT'(wordLen)) ||
                      (mistakes == countT'(maxMistakes));

    // New letter only, and never once the game is decided.
    assign accept = (state == IDLE) && !gameEnd && (guess != '0) &&
                    (guess != lastLetter) && !gameOver;

    assign setup   = (state == SET);
    assign gameRdy = (state == STOP) || (state == IDLE);
    assign busy    = (state == L0) || (state == L1) || (state == L2) ||
                     (state == L3) || (state == L4);

    // Word position checked in each compare state.
    always_comb begin
        case (state)
            L0:      pos = 3'd4;
            L1:      pos = 3'd3;
            L2:      pos = 3'd2;
            L3:      pos = 3'd1;
            default: pos = 3'd0;
        endcase
    end

    // A position counts only the first time it is found.
    assign hit = busy && (secretWord.letters[pos] == lastLetter) && !found[pos];

    // No hits in the whole word is a mistake, saturating at the limit.
    assign mistake = (state == STOP) && (hits == '0) &&
                     (mistakes < countT'(maxMistakes));

    always_comb begin
        nextState = state;
        case (state)
            SET: begin
                if (confirm) begin
                    nextState = IDLE;
                end
            end
            L0:   nextState = L1;
            L1:   nextState = L2;
            L2:   nextState = L3;
            L3:   nextState = L4;
            L4:   nextState = STOP;
            STOP: nextState = IDLE;
            IDLE: begin
                if (gameEnd) begin
                    nextState = SET;
                end else if (accept) begin
                    nextState = L0;
                end
            end
            default: nextState = SET;
        endcase
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state      <= SET;
            lastLetter <= '0;
            hits       <= '0;
            found      <= '0;
            correctQ   <= '0;
            mistakes   <= '0;
            redQ       <= 1'b0;
            greenQ     <= 1'b0;
        end else begin
            state <= nextState;
            case (state)
                SET: begin
                    lastLetter <= '0;
                    hits       <= '0;
                    found      <= '0;
                    correctQ   <= '0;
                    mistakes   <= '0;
                    redQ       <= 1'b0;
                    greenQ     <= 1'b0;
                end
                IDLE: begin
                    hits <= '0;
                    if (accept) begin
                        lastLetter <= guess;
                    end
                    // Lamps latch one cycle after the deciding score.
                    if (correctQ == countT'(wordLen)) begin
                        greenQ <= 1'b1;
                    end
                    if (mistakes == countT'(maxMistakes)) begin
                        redQ <= 1'b1;
                    end
                end
                STOP: begin
                    if (hits != '0) begin
                        if (hits <= countT'(wordLen) - correctQ) begin
                            correctQ <= correctQ + hits;
                        end
                    end else if (mistake) begin
                        mistakes <= mistakes + countT'(1);
                    end
                end
                default: begin
                    if (hit) begin
                        found[pos] <= 1'b1;
                        hits       <= hits + countT'(1);
                    end
                end
            endcase
        end
    end

    assign correct = correctQ;

    assign status.indexCorrect = found;
    assign status.incorrect    = mistakes;
    assign status.red          = redQ;
    assign status.green        = greenQ;

endmodule

// File: src/revealDisplay.sv
// Display builder for the hangman core.
// Each position shows its word letter once found, or every letter after a
// loss, and the blank character otherwise. lives is a thermometer with one
// lit bit per remaining mistake. Purely combinational.

`timescale 1ns/1ps

module revealDisplay #(
    parameter int unsigned maxMistakes = 6
) (
    input  hangmanPkg::wordT secretWord,
    gameStatusIf.disp        status,
    output hangmanPkg::wordT dispChars,
    output logic [6:0]       lives
);
    import hangmanPkg::*;

    countT livesLeft;

    always_comb begin
        if (status.incorrect >= countT'(maxMistakes)) begin
            livesLeft = '0;
        end else begin
            livesLeft = countT'(maxMistakes) - status.incorrect;
        end
    end

    // Red reveals the whole word.
    always_comb begin
        for (int i = 0; i < wordLen; i++) begin
            if (status.indexCorrect[i] || status.red) begin
                dispChars.letters[i] = secretWord.letters[i];
            end else begin
                dispChars.letters[i] = blankChar;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 7; i++) begin
            lives[i] = (i < int'(livesLeft));
        end
    end

endmodule

// File: src/hangman.sv
// Top level of the hangman game core.
// The host loads five letters with hostStrobe during setup and confirms.
// The player then holds guess letters while gameRdy is high. Status fields
// and the display outputs are brought out as plain ports.

`timescale 1ns/1ps

module hangman #(
    parameter int unsigned maxMistakes = 6
) (
    input  logic               clk,
    input  logic               nRst,
    input  hangmanPkg::letterT hostLetter,
    input  logic               hostStrobe,
    input  logic               confirm,
    input  hangmanPkg::letterT guess,
    input  logic               gameEnd,
    output logic               gameRdy,
    output logic               busy,
    output logic               mistake,
    output logic               wordFull,
    output logic               setup,
    output hangmanPkg::countT  correct,
    output hangmanPkg::countT  incorrect,
    output logic               red,
    output logic               green,
    output hangmanPkg::wordT   dispChars,
    output logic [6:0]         lives
);
    import hangmanPkg::*;

    wordT secretWord;

    gameStatusIf statusBus ();

    wordLoader loader (
        .clk        (clk),
        .nRst       (nRst),
        .setup      (setup),
        .hostLetter (hostLetter),
        .hostStrobe (hostStrobe),
        .secretWord (secretWord),
        .wordFull   (wordFull)
    );

    gameLogic #(
        .maxMistakes (maxMistakes)
    ) game (
        .clk        (clk),
        .nRst       (nRst),
        .confirm    (confirm),
        .guess      (guess),
        .gameEnd    (gameEnd),
        .secretWord (secretWord),
        .setup      (setup),
        .gameRdy    (gameRdy),
        .busy       (busy),
        .mistake    (mistake),
        .correct    (correct),
        .status     (statusBus.game)
    );

    revealDisplay #(
        .maxMistakes (maxMistakes)
    ) display (
        .secretWord (secretWord),
        .status     (statusBus.disp),
        .dispChars  (dispChars),
        .lives      (lives)
    );

    assign incorrect = statusBus.incorrect;
    assign red       = statusBus.red;
    assign green     = statusBus.green;

endmodule

// File: verif/hangmanTb.sv
// Directed testbench for the hangman game core.
// Loads secret words, plays hit, miss, win and loss sequences and checks
// counts, lamps, display and lives against a reference model kept here.
// Stops at the first mismatch; a watchdog bounds the run.

`timescale 1ns/1ps

module hangmanTb;
    import hangmanPkg::*;

    localparam int unsigned maxMistakes = 6;
    localparam int clkPeriod = 40;
    localparam int guessTotal = 14;
    localparam int marginCycles = 200;

    logic       clk;
    logic       nRst;
    letterT     hostLetter;
    logic       hostStrobe;
    logic       confirm;
    letterT     guess;
    logic       gameEnd;
    logic       gameRdy;
    logic       busy;
    logic       mistake;
    logic       wordFull;
    logic       setup;
    countT      correct;
    countT      incorrect;
    logic       red;
    logic       green;
    wordT       dispChars;
    logic [6:0] lives;

    // Reference model state.
    wordT   modelWord;
    maskT   modelMask;
    countT  modelCorrect;
    countT  modelMistakes;
    letterT modelLast;
    logic   modelRed;
    logic   modelGreen;
    int     errors;

    hangman #(
        .maxMistakes (maxMistakes)
    ) DUT (
        .clk        (clk),
        .nRst       (nRst),
        .hostLetter (hostLetter),
        .hostStrobe (hostStrobe),
        .confirm    (confirm),
        .guess      (guess),
        .gameEnd    (gameEnd),
        .gameRdy    (gameRdy),
        .busy       (busy),
        .mistake    (mistake),
        .wordFull   (wordFull),
        .setup      (setup),
        .correct    (correct),
        .incorrect  (incorrect),
        .red        (red),
        .green      (green),
        .dispChars  (dispChars),
        .lives      (lives)
    );

    always #(clkPeriod / 2) clk = ~clk;

    initial begin
        #(clkPeriod * (guessTotal * 9 + marginCycles));
        $display("Watchdog expired before the tests completed");
        $display("Some tests failed");
        $fatal(1, "simulation timed out");
    end

    task automatic stopOnError(input string line);
        $display("%s", line);
        errors++;
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compareCount(input string name, input countT got, input countT exp);
        if (got !== exp) begin
            stopOnError($sformatf("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic compareWord(input string name, input wordT got, input wordT exp);
        if (got.flat !== exp.flat) begin
            stopOnError($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got.flat, exp.flat));
        end
    endtask

    task automatic compareLetter(input string name, input letterT got, input letterT exp);
        if (got !== exp) begin
            stopOnError($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic clearModel();
        modelMask = '0;
        modelCorrect = '0;
        modelMistakes = '0;
        modelLast = '0;
        modelRed = 1'b0;
        modelGreen = 1'b0;
    endtask

    function automatic logic inWord(input letterT c);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (modelWord.letters[i] == c) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Random capital letter that misses the word and is not a repeat.
    function automatic letterT pickMiss();
        letterT c;
        do begin
            c = 8'h41 + 8'($urandom % 26);
        end while (inWord(c) || c == modelLast);
        return c;
    endfunction

    task automatic checkStatus();
        wordT       expDisp;
        logic [6:0] expLives;
        int         n;
        n = int'(maxMistakes) - int'(modelMistakes);
        expLives = 7'((1 << n) - 1);
        for (int i = 0; i < 5; i++) begin
            expDisp.letters[i] = (modelMask[i] || modelRed) ? modelWord.letters[i] : blankChar;
        end
        compareCount("correct", correct, modelCorrect);
        compareCount("incorrect", incorrect, modelMistakes);
        compareBit("red", red, modelRed);
        compareBit("green", green, modelGreen);
        compareWord("dispChars", dispChars, expDisp);
        for (int i = 0; i < 7; i++) begin
            compareBit($sformatf("lives[%0d]", i), lives[i], expLives[i]);
        end
    endtask

    task automatic strobeLetter(input letterT c);
        @(posedge clk);
        hostLetter <= c;
        hostStrobe <= 1'b1;
        @(posedge clk);
        hostStrobe <= 1'b0;
        hostLetter <= '0;
    endtask

    // First letter of the word lands in array element 4.
    task automatic loadWord(input string w);
        for (int k = 0; k < 5; k++) begin
            modelWord.letters[4 - k] = w[k];
            strobeLetter(w[k]);
        end
        @(negedge clk);
        compareBit("wordFull", wordFull, 1'b1);
    endtask

    task automatic confirmWord();
        @(negedge clk);
        compareBit("gameRdy", gameRdy, 1'b0);
        @(posedge clk);
        confirm <= 1'b1;
        @(posedge clk);
        confirm <= 1'b0;
        @(negedge clk);
        compareBit("gameRdy", gameRdy, 1'b1);
        compareBit("setup", setup, 1'b0);
    endtask

    task automatic doGuess(input letterT g);
        logic accepted;
        logic expMistake;
        int   newHits;
        int   busyCycles;
        int   mistakeCycles;
        accepted = (g != '0) && (g != modelLast) && (modelCorrect != countT'(5)) &&
                   (modelMistakes != countT'(maxMistakes));
        expMistake = 1'b0;
        newHits = 0;
        if (accepted) begin
            modelLast = g;
            for (int i = 0; i < 5; i++) begin
                if (modelWord.letters[i] == g && !modelMask[i]) begin
                    modelMask[i] = 1'b1;
                    newHits++;
                end
            end
            if (newHits > 0) begin
                modelCorrect = modelCorrect + countT'(newHits);
            end else begin
                modelMistakes = modelMistakes + countT'(1);
                expMistake = 1'b1;
            end
        end
        modelGreen = (modelCorrect == countT'(5));
        modelRed = (modelMistakes == countT'(maxMistakes));

        @(negedge clk);
        while (!gameRdy) begin
            @(negedge clk);
        end
        @(posedge clk);
        guess <= g;
        @(posedge clk);
        guess <= '0;
        busyCycles = 0;
        mistakeCycles = 0;
        repeat (7) begin
            @(negedge clk);
            if (busy) begin
                busyCycles++;
            end
            if (mistake) begin
                mistakeCycles++;
            end
        end
        // Lamps latch one cycle later.
        @(negedge clk);
        compareCount("busy cycles", countT'(busyCycles), accepted ? countT'(5) : countT'(0));
        compareCount("mistake cycles", countT'(mistakeCycles), countT'(expMistake));
        compareBit("busy", busy, 1'b0);
        checkStatus();
    endtask

    task automatic newGame();
        @(posedge clk);
        gameEnd <= 1'b1;
        @(posedge clk);
        gameEnd <= 1'b0;
        @(negedge clk);
        compareBit("setup", setup, 1'b1);
        // Counters clear on the first edge spent in setup.
        @(negedge clk);
        clearModel();
        compareBit("wordFull", wordFull, 1'b0);
        compareBit("gameRdy", gameRdy, 1'b0);
        checkStatus();
    endtask

    task automatic resetAndLoad();
        @(negedge clk);
        compareBit("setup", setup, 1'b1);
        compareBit("gameRdy", gameRdy, 1'b0);
        compareBit("busy", busy, 1'b0);
        compareBit("mistake", mistake, 1'b0);
        compareBit("wordFull", wordFull, 1'b0);
        checkStatus();
        loadWord("APPLE");
        strobeLetter("Z");
        @(negedge clk);
        compareBit("wordFull", wordFull, 1'b1);
        confirmWord();
    endtask

    task automatic hitScoring();
        doGuess("P");
        compareLetter("dispChars[3]", dispChars.letters[3], "P");
        compareLetter("dispChars[2]", dispChars.letters[2], "P");
        compareLetter("dispChars[4]", dispChars.letters[4], blankChar);
    endtask

    task automatic missScoring();
        letterT r;
        r = pickMiss();
        doGuess(r);
        doGuess(r);
        doGuess("A");
        doGuess("P");
    endtask

    task automatic winGame();
        doGuess("L");
        doGuess("E");
        repeat (3) @(negedge clk);
        compareBit("green", green, 1'b1);
        doGuess("Q");
    endtask

    task automatic lossAndNewGame();
        newGame();
        loadWord("GHOST");
        confirmWord();
        repeat (6) begin
            doGuess(pickMiss());
        end
        compareBit("red", red, 1'b1);
        compareWord("dispChars", dispChars, modelWord);
        newGame();
    endtask

    initial begin
        void'($urandom(32'hfc9a_89e5));
        errors = 0;
        modelWord = '0;
        clearModel();
        clk = 1'b0;
        nRst = 1'b0;
        hostLetter = '0;
        hostStrobe = 1'b0;
        confirm = 1'b0;
        guess = '0;
        gameEnd = 1'b0;
        repeat (5) @(posedge clk);
        nRst <= 1'b1;

        resetAndLoad();
        hitScoring();
        missScoring();
        winGame();
        lossAndNewGame();

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hangman.f
common/hangmanPkg.sv
common/gameStatusIf.sv
src/wordLoader.sv
gameLogic/gameLogic.sv
src/revealDisplay.sv
src/hangman.sv
verif/hangmanTb.sv

// File: run.sh
#!/bin/sh
# Build the hangman testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module hangmanTb \
    -f hangman.f -o hangmanSim; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/hangmanSim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "All tests passed"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
